// ==== aluCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluCore (
  opBus.alu bus
);
  import aluPkg::*;

  localparam int shW = $clog2(dataWidth);

  logic [dataWidth-1:0] addA;
  logic [dataWidth-1:0] addB;
  logic addCin;
  logic [dataWidth:0] addSum;
  logic addOvf;
  logic [shW-1:0] shAmt;
  logic [dataWidth:0] lslFull;
  logic [dataWidth:0] lsrFull;
  logic [dataWidth:0] asrFull;
  logic [2*dataWidth-1:0] rorFull;
  logic [dataWidth-1:0] result;
  logic carry;
  logic ovf;
  logic sat;
  logic known;

  // Shared adder, subtraction is a + ~b + 1 so carry means no borrow
  always_comb begin
    addA = bus.a;
    addB = bus.b;
    addCin = 1'b0;
    case (bus.op)
      ADC: addCin = bus.carryIn;
      SUB, QSUB, CMP: begin
        addB = ~bus.b;
        addCin = 1'b1;
      end
      SBC: begin
        addB = ~bus.b;
        addCin = bus.carryIn;
      end
      RSB: begin
        addA = bus.b;
        addB = ~bus.a;
        addCin = 1'b1;
      end
      default: ;
    endcase
  end

  assign addSum = {1'b0, addA} + {1'b0, addB} + {{dataWidth{1'b0}}, addCin};
  assign addOvf = (addA[dataWidth-1] == addB[dataWidth-1]) &&
                  (addSum[dataWidth-1] != addA[dataWidth-1]);

  // One extra bit on each shifter catches the last bit shifted out
  assign shAmt = bus.b[shW-1:0];
  assign lslFull = {1'b0, bus.a} << shAmt;
  assign lsrFull = {bus.a, 1'b0} >> shAmt;
  assign asrFull = $unsigned($signed({bus.a, 1'b0}) >>> shAmt);
  assign rorFull = {bus.a, bus.a} >> shAmt;

  always_comb begin
    result = '0;
    carry = bus.carryIn;
    ovf = 1'b0;
    sat = 1'b0;
    known = 1'b1;
    case (bus.op)
      ADD, ADC, SUB, SBC, RSB, CMN, CMP: begin
        result = addSum[dataWidth-1:0];
        carry = addSum[dataWidth];
        ovf = addOvf;
      end
      QADD, QSUB: begin
        result = addSum[dataWidth-1:0];
        ovf = addOvf;
        sat = addOvf;
        // Clamp toward the sign of the first operand
        if (addOvf) begin
          result = addA[dataWidth-1] ? satMin : satMax;
        end
      end
      MUL: result = bus.a * bus.b;
      AND, TST: result = bus.a & bus.b;
      BIC: result = bus.a & ~bus.b;
      ORR: result = bus.a | bus.b;
      ORN: result = bus.a | ~bus.b;
      EOR, TEQ: result = bus.a ^ bus.b;
      MOV: result = bus.b;
      LSHIFT: begin
        result = lslFull[dataWidth-1:0];
        if (shAmt != '0) carry = lslFull[dataWidth];
      end
      RSHIFT: begin
        result = lsrFull[dataWidth:1];
        if (shAmt != '0) carry = lsrFull[0];
      end
      ASHIFT: begin
        result = asrFull[dataWidth:1];
        if (shAmt != '0) carry = asrFull[0];
      end
      ROR: begin
        result = rorFull[dataWidth-1:0];
        carry = rorFull[dataWidth-1];
      end
      RRX: begin
        result = {bus.carryIn, bus.a[dataWidth-1:1]};
        carry = bus.a[0];
      end
      // Divide codes and unused codes land here
      default: known = 1'b0;
    endcase
  end

  assign bus.aluResult = result;

  always_comb begin
    bus.aluFlags = '0;
    if (known) begin
      bus.aluFlags[flagNeg] = result[dataWidth-1];
      bus.aluFlags[flagZero] = (result == '0);
      bus.aluFlags[flagCarry] = carry;
      bus.aluFlags[flagOvf] = ovf;
      bus.aluFlags[flagSat] = sat;
    end
  end

endmodule

`default_nettype wire

// ==== aluPkg.sv ====
`default_nettype none

package aluPkg;

  localparam int dataWidth = 32;
  localparam int opW = 5;
  localparam int flagW = 5;

  // Encodings follow the ARM-style ALU control word
  typedef enum logic [opW-1:0] {
    ADD = 5'd0, ADC = 5'd1, QADD = 5'd2,
    SUB = 5'd3, SBC = 5'd4, RSB = 5'd5, QSUB = 5'd6,
    MUL = 5'd7,
    UDIV = 5'd14, SDIV = 5'd15,
    AND = 5'd16, BIC = 5'd17, ORR = 5'd18, ORN = 5'd19, EOR = 5'd20,
    CMN = 5'd21, TST = 5'd22, TEQ = 5'd23, CMP = 5'd24,
    MOV = 5'd25, RSHIFT = 5'd26, ASHIFT = 5'd27, LSHIFT = 5'd28,
    ROR = 5'd29, RRX = 5'd30
  } aluOp;

  // Bit positions inside the flag word
  localparam int flagNeg = 4;
  localparam int flagZero = 3;
  localparam int flagCarry = 2;
  localparam int flagOvf = 1;
  localparam int flagSat = 0;

  // Signed saturation bounds
  localparam logic [dataWidth-1:0] satMax = 32'h7FFF_FFFF;
  localparam logic [dataWidth-1:0] satMin = 32'h8000_0000;

  // True for opcodes handled by the iterative divider
  function automatic logic isDiv(aluOp op);
    return (op == UDIV) || (op == SDIV);
  endfunction

endpackage

`default_nettype wire

// ==== build.f ====
aluPkg.sv
opBus.sv
aluCore.sv
divUnit.sv
execCtrl.sv
execUnit.sv
tbExecUnit.sv

// ==== divUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module divUnit (
  input logic clk,
  input logic arstN,
  opBus.div bus
);
  import aluPkg::*;

  localparam int cntW = $clog2(dataWidth);

  logic signedOp;
  logic [dataWidth-1:0] absA;
  logic [dataWidth-1:0] absB;
  // Dividend shifts out at the top while quotient bits shift in
  logic [dataWidth-1:0] quot;
  logic [dataWidth-1:0] rem;
  logic [dataWidth-1:0] divisor;
  logic [dataWidth:0] trial;
  logic negQ;
  logic zeroDiv;
  logic carryQ;
  logic busy;
  logic doneQ;
  logic [cntW-1:0] cnt;

  assign signedOp = (bus.op == SDIV);
  assign absA = (signedOp && bus.a[dataWidth-1]) ? -bus.a : bus.a;
  assign absB = (signedOp && bus.b[dataWidth-1]) ? -bus.b : bus.b;

  // Top bit set means the trial subtraction borrowed
  assign trial = {rem, quot[dataWidth-1]} - {1'b0, divisor};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy <= 1'b0;
      doneQ <= 1'b0;
      cnt <= '0;
    end else begin
      doneQ <= 1'b0;
      if (bus.divStart) begin
        busy <= 1'b1;
        cnt <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == cntW'(dataWidth - 1)) begin
          busy <= 1'b0;
          doneQ <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.divStart) begin
      quot <= absA;
      divisor <= absB;
      rem <= '0;
      negQ <= signedOp && (bus.a[dataWidth-1] ^ bus.b[dataWidth-1]);
      zeroDiv <= (bus.b == '0);
      carryQ <= bus.carryIn;
    end else if (busy) begin
      quot <= {quot[dataWidth-2:0], ~trial[dataWidth]};
      if (!trial[dataWidth]) rem <= trial[dataWidth-1:0];
      else rem <= {rem[dataWidth-2:0], quot[dataWidth-1]};
    end
  end

  // satMin / -1 gives magnitude 2^31, which already reads as satMin
  assign bus.divResult = zeroDiv ? '0 : (negQ ? -quot : quot);
  assign bus.divDone = doneQ;

  always_comb begin
    bus.divFlags = '0;
    bus.divFlags[flagNeg] = bus.divResult[dataWidth-1];
    bus.divFlags[flagZero] = (bus.divResult == '0);
    bus.divFlags[flagCarry] = carryQ;
  end

endmodule

`default_nettype wire

// ==== execCtrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module execCtrl #(
  parameter int queueDepth = 4,
  parameter int outCredits = 2
) (
  input logic clk,
  input logic arstN,
  input logic inValid,
  input aluPkg::aluOp inOp,
  input logic [aluPkg::dataWidth-1:0] inA,
  input logic [aluPkg::dataWidth-1:0] inB,
  input logic inCarry,
  output logic inCredit,
  output logic resValid,
  output logic [aluPkg::dataWidth-1:0] resData,
  output logic [aluPkg::flagW-1:0] resFlags,
  input logic resCredit,
  opBus.ctrl bus
);
  import aluPkg::*;

  localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int cntW = $clog2(queueDepth + 1);
  localparam int creditW = $clog2(outCredits + 1);

  typedef enum logic {IDLE, BUSY} divState;

  aluOp qOp [queueDepth];
  logic [dataWidth-1:0] qA [queueDepth];
  logic [dataWidth-1:0] qB [queueDepth];
  logic qCarry [queueDepth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic [creditW-1:0] creditCnt;
  divState state;
  logic canIssue;
  logic aluIssue;
  logic divFinish;
  logic pop;

  function automatic logic [ptrW-1:0] nextPtr(logic [ptrW-1:0] p);
    return (p == ptrW'(queueDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  // Queue head feeds both datapaths
  assign bus.op = qOp[rdPtr];
  assign bus.a = qA[rdPtr];
  assign bus.b = qB[rdPtr];
  assign bus.carryIn = qCarry[rdPtr];

  // Issue needs a head entry, an idle divider and a free result credit
  assign canIssue = (count != '0) && (state == IDLE) && (creditCnt != '0);
  assign aluIssue = canIssue && !isDiv(bus.op);
  assign bus.divStart = canIssue && isDiv(bus.op);
  assign divFinish = (state == BUSY) && bus.divDone;
  assign pop = aluIssue || divFinish;

  always_ff @(posedge clk) begin
    if (inValid) begin
      qOp[wrPtr] <= inOp;
      qA[wrPtr] <= inA;
      qB[wrPtr] <= inB;
      qCarry[wrPtr] <= inCarry;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      creditCnt <= creditW'(outCredits);
      state <= IDLE;
      inCredit <= 1'b0;
      resValid <= 1'b0;
    end else begin
      if (inValid) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      count <= count + cntW'(inValid) - cntW'(pop);
      creditCnt <= creditCnt + creditW'(resCredit) - creditW'(pop);
      // Freed slot and result leave on the same edge
      inCredit <= pop;
      resValid <= pop;
      case (state)
        IDLE: if (bus.divStart) state <= BUSY;
        BUSY: if (bus.divDone) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Result register
  always_ff @(posedge clk) begin
    if (aluIssue) begin
      resData <= bus.aluResult;
      resFlags <= bus.aluFlags;
    end else if (divFinish) begin
      resData <= bus.divResult;
      resFlags <= bus.divFlags;
    end
  end

endmodule

`default_nettype wire

// ==== execUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module execUnit #(
  parameter int queueDepth = 4,
  parameter int outCredits = 2
) (
  input logic clk,
  input logic arstN,
  input logic inValid,
  input aluPkg::aluOp inOp,
  input logic [aluPkg::dataWidth-1:0] inA,
  input logic [aluPkg::dataWidth-1:0] inB,
  input logic inCarry,
  output logic inCredit,
  output logic resValid,
  output logic [aluPkg::dataWidth-1:0] resData,
  output logic [aluPkg::flagW-1:0] resFlags,
  input logic resCredit
);

  opBus bus ();

  execCtrl #(
    .queueDepth(queueDepth),
    .outCredits(outCredits)
  ) u_execCtrl (
    .clk(clk),
    .arstN(arstN),
    .inValid(inValid),
    .inOp(inOp),
    .inA(inA),
    .inB(inB),
    .inCarry(inCarry),
    .inCredit(inCredit),
    .resValid(resValid),
    .resData(resData),
    .resFlags(resFlags),
    .resCredit(resCredit),
    .bus(bus)
  );

  aluCore u_aluCore (
    .bus(bus)
  );

  divUnit u_divUnit (
    .clk(clk),
    .arstN(arstN),
    .bus(bus)
  );

endmodule

`default_nettype wire

// ==== opBus.sv ====
`timescale 1ns/10ps
`default_nettype none

interface opBus;
  import aluPkg::*;

  // Operands from the queue head
  aluOp op;
  logic [dataWidth-1:0] a;
  logic [dataWidth-1:0] b;
  logic carryIn;

  // Single-cycle datapath result
  logic [dataWidth-1:0] aluResult;
  logic [flagW-1:0] aluFlags;

  // Divider handshake and result
  logic divStart;
  logic divDone;
  logic [dataWidth-1:0] divResult;
  logic [flagW-1:0] divFlags;

  modport ctrl (
    output op, a, b, carryIn, divStart,
    input aluResult, aluFlags, divDone, divResult, divFlags
  );
  modport alu (input op, a, b, carryIn, output aluResult, aluFlags);
  modport div (input op, a, b, carryIn, divStart, output divDone, divResult, divFlags);

endinterface

`default_nettype wire

// ==== tbExecUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbExecUnit;
  import aluPkg::*;

  localparam int queueDepth = 4;
  localparam int outCredits = 2;
  localparam int cycleLimit = 200 * 40;
  localparam longint sMax = $signed(satMax);
  localparam longint sMin = $signed(satMin);

  logic clk;
  logic arstN;
  logic inValid;
  aluOp inOp;
  logic [dataWidth-1:0] inA;
  logic [dataWidth-1:0] inB;
  logic inCarry;
  logic inCredit;
  logic resValid;
  logic [dataWidth-1:0] resData;
  logic [flagW-1:0] resFlags;
  logic resCredit;

  logic [dataWidth-1:0] expRes [$];
  logic [flagW-1:0] expFlags [$];
  aluOp expOp [$];
  int dueQ [$];
  int cycle;
  int errors;
  int startErrors;
  int passCnt;
  int failCnt;
  int upCredits;
  int outAvail;
  int accepted;
  int returned;
  logic pressure;

  aluOp singleOps [23] = '{ADD, ADC, QADD, SUB, SBC, RSB, QSUB, MUL, AND, BIC, ORR, ORN,
                           EOR, CMN, TST, TEQ, CMP, MOV, RSHIFT, ASHIFT, LSHIFT, ROR, RRX};
  aluOp shiftOps [5] = '{LSHIFT, RSHIFT, ASHIFT, ROR, RRX};

  execUnit #(
    .queueDepth(queueDepth),
    .outCredits(outCredits)
  ) u_execUnit (
    .clk(clk),
    .arstN(arstN),
    .inValid(inValid),
    .inOp(inOp),
    .inA(inA),
    .inB(inB),
    .inCarry(inCarry),
    .inCredit(inCredit),
    .resValid(resValid),
    .resData(resData),
    .resFlags(resFlags),
    .resCredit(resCredit)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Expected result and flags worked out from the per-opcode rules
  task automatic modelOp(input aluOp op, input logic [31:0] a, input logic [31:0] b,
                         input logic cin, output logic [31:0] r, output logic [4:0] f);
    longint sa;
    longint sb;
    longint s;
    int amt;
    logic c;
    logic q;
    logic chk;
    logic known;
    sa = $signed(a);
    sb = $signed(b);
    s = 0;
    amt = b[4:0];
    c = cin;
    q = 1'b0;
    chk = 1'b1;
    known = 1'b1;
    r = '0;
    case (op)
      ADD, CMN: begin
        {c, r} = {1'b0, a} + {1'b0, b};
        s = sa + sb;
      end
      ADC: begin
        {c, r} = {1'b0, a} + {1'b0, b} + {32'd0, cin};
        s = sa + sb + longint'(cin);
      end
      SUB, CMP: begin
        r = a - b;
        c = (a >= b);
        s = sa - sb;
      end
      SBC: begin
        r = a - b - {31'd0, !cin};
        c = ({1'b0, a} >= ({1'b0, b} + {32'd0, !cin}));
        s = sa - sb - longint'(!cin);
      end
      RSB: begin
        r = b - a;
        c = (b >= a);
        s = sb - sa;
      end
      QADD, QSUB: begin
        s = (op == QADD) ? sa + sb : sa - sb;
        q = (s > sMax) || (s < sMin);
        r = (s > sMax) ? satMax : ((s < sMin) ? satMin : s[31:0]);
      end
      default: chk = 1'b0;
    endcase
    case (op)
      MUL: r = a * b;
      AND, TST: r = a & b;
      BIC: r = a & ~b;
      ORR: r = a | b;
      ORN: r = a | ~b;
      EOR, TEQ: r = a ^ b;
      MOV: r = b;
      LSHIFT: begin
        r = a << amt;
        if (amt != 0) c = a[32 - amt];
      end
      RSHIFT: begin
        r = a >> amt;
        if (amt != 0) c = a[amt - 1];
      end
      ASHIFT: begin
        r = $signed(a) >>> amt;
        if (amt != 0) c = a[amt - 1];
      end
      ROR: begin
        r = (a >> amt) | (a << (32 - amt));
        c = r[31];
      end
      RRX: begin
        r = {cin, a[31:1]};
        c = a[0];
      end
      UDIV: r = (b == 0) ? '0 : a / b;
      SDIV: begin
        if (b == 0) r = '0;
        else if (a == satMin && b == '1) r = satMin;
        else r = sa / sb;
      end
      default: if (!chk) known = 1'b0;
    endcase
    f = '0;
    if (known) begin
      f[flagNeg] = r[31];
      f[flagZero] = (r == 0);
      f[flagCarry] = c;
      f[flagOvf] = chk && ((s > sMax) || (s < sMin));
      f[flagSat] = q;
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp, input aluOp op);
    assert (got === exp) else begin
      errors++;
      $display("FAILED t=%0t %s: got %h, expected %h (%s)", $time, name, got, exp, op.name());
    end
  endtask

  task automatic checkCond(input logic ok, input string what);
    assert (ok) else begin
      errors++;
      $display("Check failed at t=%0t: %s", $time, what);
    end
  endtask

  // Waits for an upstream credit, then presents one operation
  task automatic sendOp(input aluOp op, input logic [31:0] a, input logic [31:0] b,
                        input logic cin);
    logic [31:0] r;
    logic [4:0] f;
    modelOp(op, a, b, cin, r, f);
    @(posedge clk);
    while (upCredits == 0) begin
      inValid <= 1'b0;
      @(posedge clk);
    end
    inValid <= 1'b1;
    inOp <= op;
    inA <= a;
    inB <= b;
    inCarry <= cin;
    upCredits--;
    expRes.push_back(r);
    expFlags.push_back(f);
    expOp.push_back(op);
  endtask

  task automatic finishTest(input string name);
    @(posedge clk);
    inValid <= 1'b0;
    while (expRes.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    if (errors == startErrors) begin
      passCnt++;
      $display("Test %s: ok", name);
    end else begin
      failCnt++;
      $display("Test %s: %0d errors", name, errors - startErrors);
    end
    startErrors = errors;
  endtask

  // Cycle count, timeout and downstream credit return
  always @(posedge clk) begin
    cycle++;
    resCredit <= 1'b0;
    if (cycle >= cycleLimit) begin
      $display("Timeout: run exceeded %0d cycles with results still outstanding", cycleLimit);
      $display("*** FAILED ***");
      $finish;
    end else if (dueQ.size() > 0 && dueQ[0] <= cycle &&
                 !(pressure && (cycle % 40) < 30)) begin
      resCredit <= 1'b1;
      void'(dueQ.pop_front());
    end
  end

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (!arstN) begin
      checkCond(!inCredit && !resValid, "inCredit or resValid high during reset");
    end else begin
      if (inValid) accepted++;
      if (resValid) begin
        checkCond(accepted > 0, "resValid before any accepted operation");
        checkCond(outAvail > 0, "resValid with no output credit left");
        outAvail--;
        dueQ.push_back(cycle + $urandom_range(5, 0));
        if (expRes.size() == 0) begin
          checkCond(1'b0, "resValid with no operation outstanding");
        end else begin
          checkValue("resData", resData, expRes.pop_front(), expOp[0]);
          checkValue("resFlags", 32'(resFlags), 32'(expFlags.pop_front()), expOp.pop_front());
        end
      end
      if (resCredit) outAvail++;
      if (inCredit) begin
        checkCond(returned < accepted, "inCredit pulse without an accepted operation");
        returned++;
        upCredits++;
      end
      checkCond(expRes.size() <= queueDepth, "more operations outstanding than queue entries");
    end
  end

  initial begin
    logic [31:0] x;
    logic [31:0] y;
    void'($urandom(32'h990e78cf));
    arstN = 1'b0;
    inValid = 1'b0;
    inOp = ADD;
    inA = '0;
    inB = '0;
    inCarry = 1'b0;
    resCredit = 1'b0;
    pressure = 1'b0;
    cycle = 0;
    errors = 0;
    startErrors = 0;
    passCnt = 0;
    failCnt = 0;
    upCredits = queueDepth;
    outAvail = outCredits;
    accepted = 0;
    returned = 0;
    repeat (3) @(posedge clk);
    arstN <= 1'b1;
    repeat (3) @(posedge clk);
    finishTest("reset state");

    sendOp(ADD, 32'hFFFF_FFFF, 32'd1, 1'b0);
    sendOp(SUB, 32'd1, 32'd2, 1'b1);
    for (int k = 0; k < 2; k++) begin
      sendOp(ADC, 32'hFFFF_FFFE, 32'd1, k[0]);
      sendOp(SBC, 32'd5, 32'd5, k[0]);
    end
    sendOp(ADD, satMax, 32'd1, 1'b0);
    sendOp(SUB, satMin, 32'd1, 1'b0);
    foreach (singleOps[i]) begin
      repeat (2) sendOp(singleOps[i], $urandom(), $urandom(), $urandom_range(1, 0) == 1);
    end
    finishTest("arithmetic and logic");

    sendOp(QADD, satMax, 32'd1, 1'b0);
    sendOp(QADD, satMin, satMin, 1'b1);
    sendOp(QADD, 32'd5, 32'd7, 1'b0);
    sendOp(QADD, satMax, 32'd0, 1'b1);
    sendOp(QSUB, satMin, 32'd1, 1'b0);
    sendOp(QSUB, satMax, 32'hFFFF_FFFF, 1'b1);
    sendOp(QSUB, 32'd10, 32'd3, 1'b0);
    sendOp(QSUB, satMin, 32'd0, 1'b0);
    finishTest("saturation");

    foreach (shiftOps[i]) begin
      for (int k = 0; k < 4; k++) begin
        y = (k == 0) ? 32'd0 : ((k == 1) ? 32'd1 : ((k == 2) ? 32'd31 : $urandom()));
        sendOp(shiftOps[i], $urandom(), y, 1'b0);
        sendOp(shiftOps[i], $urandom(), y, 1'b1);
      end
    end
    finishTest("shifts and rotates");

    for (int k = 0; k < 8; k++) begin
      x = $urandom();
      y = $urandom() >> $urandom_range(31, 0);
      sendOp(UDIV, x, y, k[0]);
      sendOp(SDIV, x, ($urandom_range(1, 0) == 1) ? -y : y, k[1]);
    end
    sendOp(UDIV, $urandom(), 32'd0, 1'b0);
    sendOp(SDIV, $urandom(), 32'd0, 1'b1);
    sendOp(SDIV, satMin, 32'hFFFF_FFFF, 1'b0);
    sendOp(SDIV, -32'sd7, 32'd2, 1'b0);
    finishTest("division");

    // Credits held back for 30 of every 40 cycles
    pressure <= 1'b1;
    for (int k = 0; k < 40; k++) begin
      if (k % 5 == 2) sendOp(k[0] ? SDIV : UDIV, $urandom(), $urandom() >> 20, 1'b0);
      else sendOp(singleOps[$urandom_range(22, 0)], $urandom(), $urandom(), k[1]);
    end
    finishTest("ordering and credits under back-pressure");
    pressure <= 1'b0;

    checkCond(returned == accepted, "inCredit pulses do not match accepted operations");
    $display("Summary: %0d tests ok, %0d tests with errors, %0d check errors",
             passCnt, failCnt, errors);
    if (errors == 0 && failCnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
